/* source/udp_echo_pkg.sv */
package udp_echo_pkg;

    // Ethernet 14 + IPv4 20 + UDP 8
    localparam int HDR_BYTES  = 42;
    localparam int FIFO_DEPTH = 16;

    localparam logic [15:0] ETHERTYPE_IPV4  = 16'h0800;
    localparam logic [7:0]  IPV4_VER_IHL    = 8'h45;
    localparam logic [7:0]  IP_PROTO_UDP    = 8'd17;
    localparam logic [7:0]  REPLY_TTL       = 8'd64;
    localparam logic [23:0] LOCAL_IP_PREFIX = {8'd192, 8'd168, 8'd1};
    localparam logic [47:0] BROADCAST_MAC   = 48'hffff_ffff_ffff;

    typedef logic [5:0]  byte_idx_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;

    // First byte of each header field
    localparam byte_idx_t OFS_DST_MAC    = 6'd0;
    localparam byte_idx_t OFS_SRC_MAC    = 6'd6;
    localparam byte_idx_t OFS_ETH_TYPE   = 6'd12;
    localparam byte_idx_t OFS_VER_IHL    = 6'd14;
    localparam byte_idx_t OFS_IP_LENGTH  = 6'd16;
    localparam byte_idx_t OFS_PROTOCOL   = 6'd23;
    localparam byte_idx_t OFS_SRC_IP     = 6'd26;
    localparam byte_idx_t OFS_DST_IP     = 6'd30;
    localparam byte_idx_t OFS_SRC_PORT   = 6'd34;
    localparam byte_idx_t OFS_DST_PORT   = 6'd36;
    localparam byte_idx_t OFS_UDP_LENGTH = 6'd38;

    typedef enum logic [1:0] {
        ST_RX_HDR,
        ST_DROP,
        ST_TX_HDR,
        ST_TX_PAYLOAD
    } echo_state_t;

endpackage

/* source/byte_counter.sv */
`timescale 1ns/1ps

module byte_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    advance,
    output udp_echo_pkg::byte_idx_t index,
    output logic                    hdr_done
);
    import udp_echo_pkg::*;

    localparam byte_idx_t LAST_IDX = byte_idx_t'(HDR_BYTES - 1);

    assign hdr_done = advance && (index == LAST_IDX);

    // Sticks at the last header byte until cleared
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index <= '0;
        end else if (clear) begin
            index <= '0;
        end else if (advance && index != LAST_IDX) begin
            index <= index + 1'b1;
        end
    end

endmodule

/* source/echo_frame_fsm.sv */
`timescale 1ns/1ps

module echo_frame_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic                      in_last,
    output logic                      in_ready,
    input  logic                      rx_hdr_done,
    input  logic                      hdr_match,
    input  logic                      tx_hdr_done,
    input  logic                      fifo_full,
    input  logic                      fifo_out_last,
    input  logic                      out_handshake,
    output udp_echo_pkg::echo_state_t state,
    output logic                      rx_advance,
    output logic                      tx_advance,
    output logic                      fifo_write
);
    import udp_echo_pkg::*;

    // Set while the payload of the matched frame is still arriving
    logic payload_open;

    // Header and dropped bytes are always taken, payload only with FIFO room
    assign in_ready   = (state == ST_RX_HDR) || (state == ST_DROP) ||
                        (payload_open && !fifo_full);
    assign rx_advance = (state == ST_RX_HDR) && in_valid;
    assign tx_advance = (state == ST_TX_HDR) && out_handshake;
    assign fifo_write = payload_open && in_valid && !fifo_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_RX_HDR;
            payload_open <= 1'b0;
        end else begin
            if (fifo_write && in_last) begin
                payload_open <= 1'b0;
            end
            case (state)
                ST_RX_HDR: begin
                    // A frame ending inside the header just restarts the count
                    if (rx_hdr_done && !in_last) begin
                        if (hdr_match) begin
                            state        <= ST_TX_HDR;
                            payload_open <= 1'b1;
                        end else begin
                            state <= ST_DROP;
                        end
                    end
                end
                ST_DROP: begin
                    if (in_valid && in_last) begin
                        state <= ST_RX_HDR;
                    end
                end
                ST_TX_HDR: begin
                    if (tx_hdr_done) begin
                        state <= ST_TX_PAYLOAD;
                    end
                end
                ST_TX_PAYLOAD: begin
                    if (out_handshake && fifo_out_last) begin
                        state <= ST_RX_HDR;
                    end
                end
                default: state <= ST_RX_HDR;
            endcase
        end
    end

endmodule

/* source/rx_header_parser.sv */
`timescale 1ns/1ps

module rx_header_parser (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              in_data,
    input  logic                    capture,
    input  udp_echo_pkg::byte_idx_t index,
    input  udp_echo_pkg::mac_t      local_mac,
    input  udp_echo_pkg::ip_t       local_ip,
    output logic                    hdr_match,
    output udp_echo_pkg::mac_t      src_mac,
    output udp_echo_pkg::ip_t       src_ip,
    output udp_echo_pkg::port_t     src_port,
    output udp_echo_pkg::port_t     dst_port,
    output logic [15:0]             ip_length,
    output logic [15:0]             udp_length
);
    import udp_echo_pkg::*;

    mac_t        dst_mac;
    logic [15:0] eth_type;
    logic [7:0]  ver_ihl;
    logic [7:0]  protocol;
    ip_t         dst_ip;
    logic        match_now;

    function automatic logic in_field(byte_idx_t idx, byte_idx_t ofs, int len);
        return (int'(idx) >= int'(ofs)) && (int'(idx) < int'(ofs) + len);
    endfunction

    // Fields arrive big-endian, so each one shifts in from the right
    always_ff @(posedge clk) begin
        if (capture) begin
            if (in_field(index, OFS_DST_MAC, 6))    dst_mac    <= {dst_mac[39:0], in_data};
            if (in_field(index, OFS_SRC_MAC, 6))    src_mac    <= {src_mac[39:0], in_data};
            if (in_field(index, OFS_ETH_TYPE, 2))   eth_type   <= {eth_type[7:0], in_data};
            if (in_field(index, OFS_VER_IHL, 1))    ver_ihl    <= in_data;
            if (in_field(index, OFS_IP_LENGTH, 2))  ip_length  <= {ip_length[7:0], in_data};
            if (in_field(index, OFS_PROTOCOL, 1))   protocol   <= in_data;
            if (in_field(index, OFS_SRC_IP, 4))     src_ip     <= {src_ip[23:0], in_data};
            if (in_field(index, OFS_DST_IP, 4))     dst_ip     <= {dst_ip[23:0], in_data};
            if (in_field(index, OFS_SRC_PORT, 2))   src_port   <= {src_port[7:0], in_data};
            if (in_field(index, OFS_DST_PORT, 2))   dst_port   <= {dst_port[7:0], in_data};
            if (in_field(index, OFS_UDP_LENGTH, 2)) udp_length <= {udp_length[7:0], in_data};
        end
    end

    assign match_now = ((dst_mac == local_mac) || (dst_mac == BROADCAST_MAC)) &&
                       (eth_type == ETHERTYPE_IPV4) &&
                       (ver_ihl == IPV4_VER_IHL) &&
                       (protocol == IP_PROTO_UDP) &&
                       (dst_ip == local_ip);

    // Match fields end at byte 33, well before the decision at byte 41
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_match <= 1'b0;
        end else begin
            hdr_match <= match_now;
        end
    end

endmodule

/* source/payload_fifo.sv */
`timescale 1ns/1ps

module payload_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] wr_data,
    input  logic       wr_last,
    input  logic       wr_en,
    output logic       full,
    output logic [7:0] rd_data,
    output logic       rd_last,
    output logic       rd_valid,
    input  logic       rd_en
);
    import udp_echo_pkg::*;

    logic [8:0] mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic do_write;
    logic do_read;

    assign full     = (count == FIFO_DEPTH);
    assign rd_valid = (count != 0);
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && rd_valid;
    assign {rd_last, rd_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= {wr_last, wr_data};
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_write - do_read;
        end
    end

endmodule

/* source/tx_header_builder.sv */
`timescale 1ns/1ps

module tx_header_builder (
    input  udp_echo_pkg::byte_idx_t index,
    input  udp_echo_pkg::mac_t      local_mac,
    input  udp_echo_pkg::ip_t       local_ip,
    input  udp_echo_pkg::mac_t      src_mac,
    input  udp_echo_pkg::ip_t       src_ip,
    input  udp_echo_pkg::port_t     src_port,
    input  udp_echo_pkg::port_t     dst_port,
    input  logic [15:0]             ip_length,
    input  logic [15:0]             udp_length,
    output logic [7:0]              hdr_byte
);
    import udp_echo_pkg::*;

    logic [19:0] csum_sum;
    logic [16:0] csum_fold;
    logic [15:0] ip_csum;
    logic [8*HDR_BYTES-1:0] hdr;

    // Identification, flags and the checksum field itself add nothing
    always_comb begin
        csum_sum  = {IPV4_VER_IHL, 8'h00} + ip_length + {REPLY_TTL, IP_PROTO_UDP} +
                    local_ip[31:16] + local_ip[15:0] + src_ip[31:16] + src_ip[15:0];
        csum_fold = csum_sum[15:0] + csum_sum[19:16];
        ip_csum   = ~(csum_fold[15:0] + csum_fold[16]);
    end

    // Reply header with byte 0 in the top bits
    assign hdr = {
        src_mac, local_mac, ETHERTYPE_IPV4,
        IPV4_VER_IHL, 8'h00, ip_length,
        16'h0000, 16'h0000,
        REPLY_TTL, IP_PROTO_UDP, ip_csum,
        local_ip, src_ip,
        dst_port, src_port, udp_length, 16'h0000
    };

    assign hdr_byte = hdr[8*(HDR_BYTES - 1 - int'(index)) +: 8];

endmodule

/* source/udp_echo_core.sv */
`timescale 1ns/1ps

module udp_echo_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [95:0] dna,
    input  logic [7:0]  in_data,
    input  logic        in_valid,
    input  logic        in_last,
    output logic        in_ready,
    output logic [7:0]  out_data,
    output logic        out_valid,
    output logic        out_last,
    input  logic        out_ready
);
    import udp_echo_pkg::*;

    mac_t        local_mac;
    ip_t         local_ip;
    echo_state_t state;
    byte_idx_t   rx_index;
    byte_idx_t   tx_index;
    logic        rx_advance;
    logic        tx_advance;
    logic        rx_clear;
    logic        tx_clear;
    logic        rx_hdr_done;
    logic        tx_hdr_done;
    logic        hdr_match;
    mac_t        src_mac;
    ip_t         src_ip;
    port_t       src_port;
    port_t       dst_port;
    logic [15:0] ip_length;
    logic [15:0] udp_length;
    logic        fifo_write;
    logic        fifo_full;
    logic        fifo_read;
    logic [7:0]  fifo_data;
    logic        fifo_last;
    logic        fifo_valid;
    logic [7:0]  hdr_byte;
    logic        out_handshake;

    // Locally administered unicast MAC and a fixed /24 address
    assign local_mac = {dna[47:42], 2'b10, dna[39:0]};
    assign local_ip  = {LOCAL_IP_PREFIX, dna[7:0]};

    // Counters rest at zero outside their phase; a short frame restarts rx
    assign rx_clear = (state != ST_RX_HDR) || (rx_advance && in_last);
    assign tx_clear = (state != ST_TX_HDR);

    // Header bytes first, then the FIFO head
    assign out_valid     = (state == ST_TX_HDR) || ((state == ST_TX_PAYLOAD) && fifo_valid);
    assign out_data      = (state == ST_TX_PAYLOAD) ? fifo_data : hdr_byte;
    assign out_last      = (state == ST_TX_PAYLOAD) && fifo_last;
    assign out_handshake = out_valid && out_ready;
    assign fifo_read     = (state == ST_TX_PAYLOAD) && out_handshake;

    echo_frame_fsm fsm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .in_ready      (in_ready),
        .rx_hdr_done   (rx_hdr_done),
        .hdr_match     (hdr_match),
        .tx_hdr_done   (tx_hdr_done),
        .fifo_full     (fifo_full),
        .fifo_out_last (fifo_last),
        .out_handshake (out_handshake),
        .state         (state),
        .rx_advance    (rx_advance),
        .tx_advance    (tx_advance),
        .fifo_write    (fifo_write)
    );

    byte_counter rx_count_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (rx_clear),
        .advance  (rx_advance),
        .index    (rx_index),
        .hdr_done (rx_hdr_done)
    );

    byte_counter tx_count_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (tx_clear),
        .advance  (tx_advance),
        .index    (tx_index),
        .hdr_done (tx_hdr_done)
    );

    rx_header_parser parser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_data    (in_data),
        .capture    (rx_advance),
        .index      (rx_index),
        .local_mac  (local_mac),
        .local_ip   (local_ip),
        .hdr_match  (hdr_match),
        .src_mac    (src_mac),
        .src_ip     (src_ip),
        .src_port   (src_port),
        .dst_port   (dst_port),
        .ip_length  (ip_length),
        .udp_length (udp_length)
    );

    payload_fifo fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_data  (in_data),
        .wr_last  (in_last),
        .wr_en    (fifo_write),
        .full     (fifo_full),
        .rd_data  (fifo_data),
        .rd_last  (fifo_last),
        .rd_valid (fifo_valid),
        .rd_en    (fifo_read)
    );

    tx_header_builder builder_i (
        .index      (tx_index),
        .local_mac  (local_mac),
        .local_ip   (local_ip),
        .src_mac    (src_mac),
        .src_ip     (src_ip),
        .src_port   (src_port),
        .dst_port   (dst_port),
        .ip_length  (ip_length),
        .udp_length (udp_length),
        .hdr_byte   (hdr_byte)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Released 1 ns after the last reset edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* tb/udp_echo_properties.sv */
`timescale 1ns/1ps

module udp_echo_properties (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       in_ready,
    input logic [7:0] out_data,
    input logic       out_valid,
    input logic       out_last,
    input logic       out_ready
);
    int assert_failures = 0;

    // A stalled output byte stays on the bus
    out_stall_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            assert_failures++;
            $error("out_valid or out_data changed while out_ready was low");
        end

    // Ready only falls after a byte has been taken
    in_ready_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready && !in_valid |=> in_ready)
        else begin
            assert_failures++;
            $error("in_ready fell while the input was idle");
        end

    out_idle_after_reset_a: assert property (@(posedge clk)
        !rst_n |=> !out_valid)
        else begin
            assert_failures++;
            $error("out_valid high after a reset cycle");
        end

endmodule

bind udp_echo_core udp_echo_properties props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
);

/* tb/udp_echo_tb.sv */
`timescale 1ns/1ps

module udp_echo_tb;
    import udp_echo_pkg::*;

    localparam int NUM_FRAMES       = 40;
    localparam int CYCLES_PER_FRAME = 200;
    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 1;
    localparam int QUIET_CYCLES     = 50;
    localparam int SEED             = 75;

    localparam int KIND_GOOD      = 0;
    localparam int KIND_BCAST     = 1;
    localparam int KIND_BAD_TYPE  = 2;
    localparam int KIND_BAD_VER   = 3;
    localparam int KIND_BAD_PROTO = 4;
    localparam int KIND_BAD_IP    = 5;
    localparam int KIND_BAD_MAC   = 6;
    localparam int KIND_SHORT     = 7;

    logic        clk;
    logic        rst_n;
    logic [95:0] dna;
    logic [7:0]  in_data;
    logic        in_valid;
    logic        in_last;
    logic        in_ready;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        out_last;
    logic        out_ready;

    logic [47:0] local_mac;
    logic [31:0] local_ip;
    logic [7:0]  frame_q[$];
    logic [7:0]  reply_q[$];
    // Expected output stream with the last flag in bit 8
    logic [8:0]  expect_q[$];

    int          value_errors     = 0;
    int          other_errors     = 0;
    int          expected_replies = 0;
    int          replies_seen     = 0;
    int          out_pos          = 0;
    logic [31:0] ip_sum           = '0;

    tb_clock_gen clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    udp_echo_core dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dna       (dna),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    // Low 48 DNA bits with bit 41 set and bit 40 cleared
    assign local_mac = (dna[47:0] & ~48'h0300_0000_0000) | 48'h0200_0000_0000;
    assign local_ip  = {8'd192, 8'd168, 8'd1, dna[7:0]};

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error: %s expected 0x%h, got 0x%h at %0d ns",
                     name, expected, actual, $time);
        end
    endtask

    function automatic logic [15:0] fold_sum(input logic [31:0] acc);
        logic [31:0] s;
        s = acc;
        while (s[31:16] != 16'h0000) begin
            s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
        end
        return s[15:0];
    endfunction

    // Big-endian field into the frame or the expected reply header
    task automatic append_field(input logic [47:0] value, input int count, input bit to_reply);
        for (int k = 0; k < count; k++) begin
            if (to_reply) begin
                reply_q.push_back(value[8*(count-1-k) +: 8]);
            end else begin
                frame_q.push_back(value[8*(count-1-k) +: 8]);
            end
        end
    endtask

    task automatic build_frame(input int kind, input int plen);
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
        logic [7:0]  ver_ihl;
        logic [7:0]  protocol;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        logic [15:0] csum;
        logic [31:0] acc;
        logic [7:0]  payload[$];
        int          short_len;

        dst_mac  = (kind == KIND_BCAST) ? BROADCAST_MAC : local_mac;
        eth_type = ETHERTYPE_IPV4;
        ver_ihl  = 8'h45;
        protocol = IP_PROTO_UDP;
        dst_ip   = local_ip;
        case (kind)
            KIND_BAD_TYPE:  eth_type = 16'h0806;
            KIND_BAD_VER:   ver_ihl = 8'h46;
            KIND_BAD_PROTO: protocol = 8'd6;
            KIND_BAD_IP:    dst_ip = local_ip ^ 32'h0000_0001;
            KIND_BAD_MAC:   dst_mac = local_mac ^ 48'h0000_0000_0001;
            default: ;
        endcase
        src_mac  = {16'($urandom), $urandom};
        src_ip   = $urandom;
        src_port = 16'($urandom);
        dst_port = 16'($urandom);
        udp_len  = 16'(8 + plen);
        ip_len   = 16'(28 + plen);

        frame_q.delete();
        append_field(dst_mac, 6, 1'b0);
        append_field(src_mac, 6, 1'b0);
        append_field(48'(eth_type), 2, 1'b0);
        append_field(48'(ver_ihl), 1, 1'b0);
        append_field(48'($urandom), 1, 1'b0);
        append_field(48'(ip_len), 2, 1'b0);
        // Identification, flags and TTL are ignored by the responder
        append_field(48'($urandom), 5, 1'b0);
        append_field(48'(protocol), 1, 1'b0);
        append_field(48'($urandom), 2, 1'b0);
        append_field(48'(src_ip), 4, 1'b0);
        append_field(48'(dst_ip), 4, 1'b0);
        append_field(48'(src_port), 2, 1'b0);
        append_field(48'(dst_port), 2, 1'b0);
        append_field(48'(udp_len), 2, 1'b0);
        append_field(48'($urandom), 2, 1'b0);
        for (int k = 0; k < plen; k++) begin
            payload.push_back(8'($urandom));
            frame_q.push_back(payload[k]);
        end

        if (kind == KIND_SHORT) begin
            short_len = 1 + int'($urandom % 41);
            while (frame_q.size() > short_len) begin
                void'(frame_q.pop_back());
            end
        end else if (kind == KIND_GOOD || kind == KIND_BCAST) begin
            reply_q.delete();
            append_field(src_mac, 6, 1'b1);
            append_field(local_mac, 6, 1'b1);
            append_field(48'(ETHERTYPE_IPV4), 2, 1'b1);
            append_field(48'h4500, 2, 1'b1);
            append_field(48'(ip_len), 2, 1'b1);
            append_field(48'h0, 4, 1'b1);
            append_field(48'({REPLY_TTL, IP_PROTO_UDP}), 2, 1'b1);
            append_field(48'h0, 2, 1'b1);
            append_field(48'(local_ip), 4, 1'b1);
            append_field(48'(src_ip), 4, 1'b1);
            append_field(48'(dst_port), 2, 1'b1);
            append_field(48'(src_port), 2, 1'b1);
            append_field(48'(udp_len), 2, 1'b1);
            append_field(48'h0, 2, 1'b1);
            acc = '0;
            for (int k = 14; k < 34; k += 2) begin
                acc += 32'({reply_q[k], reply_q[k+1]});
            end
            csum = ~fold_sum(acc);
            reply_q[24] = csum[15:8];
            reply_q[25] = csum[7:0];
            foreach (reply_q[k]) begin
                expect_q.push_back({1'b0, reply_q[k]});
            end
            foreach (payload[k]) begin
                expect_q.push_back({k == plen - 1, payload[k]});
            end
            expected_replies++;
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_frame();
        int gap;
        bit taken;
        for (int k = 0; k < frame_q.size(); k++) begin
            if ($urandom % 4 == 0) begin
                in_valid = 1'b0;
                gap = 1 + int'($urandom % 3);
                repeat (gap) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
            end
            in_valid = 1'b1;
            in_data  = frame_q[k];
            in_last  = (k == frame_q.size() - 1);
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_for_replies();
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        // Catch stray output after the last reply
        repeat (QUIET_CYCLES) @(posedge clk);
        if (replies_seen != expected_replies) begin
            other_errors++;
            $display("Expected %0d replies but %0d were received",
                     expected_replies, replies_seen);
        end
    endtask

    task automatic report_and_finish(input bit timed_out);
        int total;
        total = value_errors + other_errors + dut_i.props_i.assert_failures;
        $display("Errors: %0d value, %0d other, %0d assertion; %0d of %0d replies seen",
                 value_errors, other_errors, dut_i.props_i.assert_failures,
                 replies_seen, expected_replies);
        if (timed_out || total != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    endtask

    initial begin
        int kind;
        int plen;
        void'($urandom(SEED));
        dna       = {$urandom, $urandom, $urandom};
        in_data   = 8'h00;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            // Every kind once, then a random mix ending on a good frame
            if (i < 8) begin
                kind = i;
            end else if (i == NUM_FRAMES - 1) begin
                kind = KIND_GOOD;
            end else begin
                kind = int'($urandom % 8);
            end
            if (i == 0) begin
                plen = 1;
            end else if (i == 1) begin
                plen = 64;
            end else begin
                plen = 1 + int'($urandom % 64);
            end
            build_frame(kind, plen);
            send_frame();
        end
        wait_for_replies();
        report_and_finish(1'b0);
    end

    // Random back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            out_ready = ($urandom % 4 != 0);
        end
    end

    // Output sampled mid-cycle, where it is settled
    always @(negedge clk) begin
        logic [8:0] exp_entry;
        if (rst_n && out_valid && out_ready) begin
            if (expect_q.size() == 0) begin
                other_errors++;
                $display("Unexpected output byte 0x%h with no reply pending at %0d ns",
                         out_data, $time);
            end else begin
                exp_entry = expect_q.pop_front();
                check_value("out_data", 16'(exp_entry[7:0]), 16'(out_data));
                check_value("out_last", 16'(exp_entry[8]), 16'(out_last));
            end
            if (out_pos >= 14 && out_pos < 34) begin
                ip_sum += (out_pos % 2 == 0) ? {16'h0000, out_data, 8'h00}
                                             : {24'h000000, out_data};
            end
            if (out_pos == 33) begin
                check_value("ip_header_sum", 16'hffff, fold_sum(ip_sum));
            end
            out_pos++;
            if (out_last) begin
                out_pos = 0;
                ip_sum  = '0;
                replies_seen++;
            end
        end
    end

    initial begin
        #(NUM_FRAMES * CYCLES_PER_FRAME * CLK_PERIOD);
        other_errors++;
        $display("Timeout after %0d cycles with %0d reply bytes still outstanding",
                 NUM_FRAMES * CYCLES_PER_FRAME, expect_q.size());
        report_and_finish(1'b1);
    end

endmodule

/* tb.f */
source/udp_echo_pkg.sv
source/byte_counter.sv
source/echo_frame_fsm.sv
source/rx_header_parser.sv
source/payload_fifo.sv
source/tx_header_builder.sv
source/udp_echo_core.sv
tb/tb_clock_gen.sv
tb/udp_echo_properties.sv
tb/udp_echo_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := udp_echo_tb
FILE_LIST := tb.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_FLAGS := +verilator+error+limit+1000
PASS_TEXT := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
